// ==== Makefile ====
# Verilator build and run for the flow control unit testbench

SRCS := $(shell cat flist.f)

.PHONY: run clean

run: obj_dir/Vfcu_tb
	@out=$$(./obj_dir/Vfcu_tb); echo "$$out"; echo "$$out" | grep -qx "all tests passed"

obj_dir/Vfcu_tb: flist.f $(SRCS)
	verilator --binary --timing --assert -f flist.f --top-module fcu_tb -o Vfcu_tb

clean:
	rm -rf obj_dir

// ==== flist.f ====
source/fcu_pkg.sv
source/fcu_decode.sv
source/fcu_result_calc.sv
source/fcu_branch_eval.sv
source/fcu_top.sv
tests/fcu_clock_gen.sv
tests/fcu_checker.sv
tests/fcu_tb.sv

// ==== source/fcu_branch_eval.sv ====
// ==============================
// Redirect decision and target for a decoded record, combinational
// Illegal cases never redirect, target is zero without redirect
// Targets wrap modulo the 32-bit address space
// ==============================
`timescale 1ns/1ps
`default_nettype none

module fcu_branch_eval (
    input  fcu_pkg::fcu_dec_t  dec,
    output fcu_pkg::fcu_flow_t flow
);

    fcu_pkg::fcu_word_t  cnt_inc;
    fcu_pkg::fcu_word_t  cnt_dec;
    fcu_pkg::fcu_addr_t  branch_target;
    fcu_pkg::fcu_addr_t  jump_target;
    fcu_pkg::fcu_addr_t  trap_target;
    fcu_pkg::fcu_level_t inv_ol;
    logic                rex_taken;
    logic                take;
    logic                illegal;
    fcu_pkg::fcu_addr_t  target;

    // ==============================
    // Conditions and targets
    // ==============================
    assign cnt_inc = dec.a + fcu_pkg::fcu_word_t'(1);
    assign cnt_dec = dec.a - fcu_pkg::fcu_word_t'(1);

    // PC-relative for branches, register-relative for jumps
    assign branch_target = dec.next_pc + dec.disp;
    assign jump_target   = dec.a[fcu_pkg::ADDR_W-1:0] + dec.disp;
    assign trap_target   = dec.tvec[fcu_pkg::ADDR_W-1:0];

    assign inv_ol    = ~dec.ol;
    assign rex_taken = (dec.im < inv_ol);

    // ==============================
    // Decision
    // ==============================
    always_comb
    begin
        take    = 1'b0;
        illegal = 1'b0;
        target  = '0;
        case (dec.op)
            fcu_pkg::OP_BRK:
            begin
                take   = 1'b1;
                target = trap_target;
            end
            fcu_pkg::OP_BBC:
            begin
                target = branch_target;
                case (dec.cond)
                    fcu_pkg::COND_IBNE: take = (cnt_inc != dec.i);
                    fcu_pkg::COND_DBNZ: take = (cnt_dec != '0);
                    default:            illegal = 1'b1;
                endcase
            end
            fcu_pkg::OP_JAL,
            fcu_pkg::OP_CALL:
            begin
                take   = 1'b1;
                target = jump_target;
            end
            fcu_pkg::OP_RET:
            begin
                take   = 1'b1;
                target = dec.link;
            end
            fcu_pkg::OP_REX:
            begin
                // User level may not leave the handler
                if (dec.ol == fcu_pkg::OL_USER)
                begin
                    illegal = 1'b1;
                end
                else
                begin
                    take   = rex_taken;
                    target = trap_target;
                end
            end
            fcu_pkg::OP_WAIT:
                take = 1'b0;
            default:
                illegal = 1'b1;
        endcase
    end

    // Zero the target when not taken
    assign flow.redirect = take;
    assign flow.target   = take ? target : '0;
    assign flow.illegal  = illegal;

endmodule

`default_nettype wire

// ==== source/fcu_decode.sv ====
// ==============================
// First stage, one cycle after the issue strobe
// Record is held between strobes, only the valid bit resets
// ==============================
`timescale 1ns/1ps
`default_nettype none

module fcu_decode (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              issue_valid,
    input  fcu_pkg::fcu_req_t req,
    output logic              dec_valid,
    output fcu_pkg::fcu_dec_t dec
);

    logic [fcu_pkg::OPC_W-1:0]  opcode;
    logic [fcu_pkg::DISP_W-1:0] disp_raw;
    fcu_pkg::fcu_op_e           op_class;
    fcu_pkg::fcu_addr_t         disp_bytes;

    // ==============================
    // Field extraction
    // ==============================
    assign opcode   = req.instr[fcu_pkg::OPC_LSB +: fcu_pkg::OPC_W];
    assign disp_raw = req.instr[fcu_pkg::DISP_LSB +: fcu_pkg::DISP_W];

    // Sign extend, then scale words to bytes
    assign disp_bytes = {{(fcu_pkg::ADDR_W - fcu_pkg::DISP_W - 2){disp_raw[fcu_pkg::DISP_W-1]}},
                         disp_raw, 2'b00};

    // Known opcodes keep their code, the rest fold into UNDEF
    always_comb
    begin
        case (opcode)
            fcu_pkg::OP_BRK,
            fcu_pkg::OP_BBC,
            fcu_pkg::OP_JAL,
            fcu_pkg::OP_CALL,
            fcu_pkg::OP_RET,
            fcu_pkg::OP_REX,
            fcu_pkg::OP_WAIT:
                op_class = fcu_pkg::fcu_op_e'(opcode);
            default:
                op_class = fcu_pkg::OP_UNDEF;
        endcase
    end

    // ==============================
    // Stage register
    // ==============================
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            dec_valid <= 1'b0;
        end
        else
        begin
            dec_valid <= issue_valid;
        end
    end

    // Payload loads only on a strobe
    always_ff @(posedge clk)
    begin
        if (issue_valid)
        begin
            dec.op      <= op_class;
            dec.cond    <= req.instr[fcu_pkg::COND_LSB +: fcu_pkg::COND_W];
            dec.cause   <= req.instr[fcu_pkg::CAUSE_LSB +: fcu_pkg::CAUSE_W];
            dec.disp    <= disp_bytes;
            dec.a       <= req.a;
            dec.i       <= req.i;
            dec.next_pc <= req.next_pc;
            dec.link    <= req.link;
            dec.tvec    <= req.tvec;
            dec.waitctr <= req.waitctr;
            dec.ol      <= req.ol;
            dec.im      <= req.im;
        end
    end

endmodule

`default_nettype wire

// ==== source/fcu_pkg.sv ====
// ==============================
// Shared widths, encodings and records for the flow control unit
// Opcode and condition codes are local choices and must match the issue logic
// Addresses are 32-bit byte addresses and the displacement counts words
// Undefined cases return FILL_PATTERN
// ==============================
`default_nettype none

package fcu_pkg;

    // ==============================
    // Widths
    // ==============================
    localparam int WORD_W  = 64;
    localparam int ADDR_W  = 32;
    localparam int INSTR_W = 32;
    localparam int LEVEL_W = 3;

    // Instruction field positions
    localparam int OPC_LSB   = 0;
    localparam int OPC_W     = 6;
    localparam int CAUSE_LSB = 6;
    localparam int CAUSE_W   = 7;
    localparam int COND_LSB  = 17;
    localparam int COND_W    = 3;
    localparam int DISP_LSB  = 20;
    localparam int DISP_W    = 12;

    typedef logic [WORD_W-1:0]  fcu_word_t;
    typedef logic [ADDR_W-1:0]  fcu_addr_t;
    typedef logic [LEVEL_W-1:0] fcu_level_t;

    // User level, the only level that may not return from an interrupt
    localparam fcu_level_t OL_USER = 3'b011;

    // Every byte CC, returned when no defined result exists
    localparam fcu_word_t FILL_PATTERN = {(WORD_W / 8){8'hCC}};

    // ==============================
    // Encodings
    // ==============================
    // OP_UNDEF is never issued, decode uses it for unknown opcodes
    typedef enum logic [OPC_W-1:0] {
        OP_BRK   = 6'h00,
        OP_REX   = 6'h0D,
        OP_WAIT  = 6'h0E,
        OP_JAL   = 6'h18,
        OP_CALL  = 6'h19,
        OP_BBC   = 6'h26,
        OP_RET   = 6'h29,
        OP_UNDEF = 6'h3F
    } fcu_op_e;

    // Counting branch conditions, other codes are illegal
    typedef enum logic [COND_W-1:0] {
        COND_IBNE = 3'b110,
        COND_DBNZ = 3'b111
    } fcu_cond_e;

    // ==============================
    // Records
    // ==============================
    // Issued instruction with its operands
    typedef struct packed {
        logic [INSTR_W-1:0] instr;
        fcu_word_t          a;
        fcu_word_t          i;
        fcu_addr_t          next_pc;
        fcu_addr_t          link;
        fcu_word_t          tvec;
        fcu_word_t          waitctr;
        fcu_level_t         ol;
        fcu_level_t         im;
    } fcu_req_t;

    // Decoded record, disp already scaled to bytes
    typedef struct packed {
        fcu_op_e             op;
        logic [COND_W-1:0]   cond;
        logic [CAUSE_W-1:0]  cause;
        fcu_addr_t           disp;
        fcu_word_t           a;
        fcu_word_t           i;
        fcu_addr_t           next_pc;
        fcu_addr_t           link;
        fcu_word_t           tvec;
        fcu_word_t           waitctr;
        fcu_level_t          ol;
        fcu_level_t          im;
    } fcu_dec_t;

    // Control-flow decision, target is zero without redirect
    typedef struct packed {
        logic      redirect;
        fcu_addr_t target;
        logic      illegal;
    } fcu_flow_t;

    typedef struct packed {
        fcu_word_t result;
        fcu_flow_t flow;
    } fcu_rsp_t;

endpackage

`default_nettype wire

// ==== source/fcu_result_calc.sv ====
// ==============================
// Write-back value for a decoded record, combinational
// Undefined opcodes, conditions and user-level REX give the fill pattern
// ==============================
`timescale 1ns/1ps
`default_nettype none

module fcu_result_calc (
    input  fcu_pkg::fcu_dec_t  dec,
    output fcu_pkg::fcu_word_t result
);

    localparam int ONES_W = fcu_pkg::WORD_W - fcu_pkg::CAUSE_W;

    fcu_pkg::fcu_word_t  brk_value;
    fcu_pkg::fcu_word_t  link_value;
    fcu_pkg::fcu_level_t inv_ol;
    logic                rex_taken;
    logic                wait_done;

    // ==============================
    // Candidate values
    // ==============================
    // Cause under an all-ones top part
    assign brk_value = {{ONES_W{1'b1}}, dec.cause};

    // Link address zero-extended to a word
    assign link_value = fcu_pkg::fcu_word_t'(dec.next_pc);

    // Mask below the inverted level takes the trap
    assign inv_ol    = ~dec.ol;
    assign rex_taken = (dec.im < inv_ol);

    assign wait_done = (dec.waitctr == fcu_pkg::fcu_word_t'(1));

    // ==============================
    // Select by operation class
    // ==============================
    always_comb
    begin
        case (dec.op)
            fcu_pkg::OP_BRK:
                result = brk_value;
            fcu_pkg::OP_BBC:
            begin
                // Counter step, direction from the condition
                case (dec.cond)
                    fcu_pkg::COND_IBNE: result = dec.a + fcu_pkg::fcu_word_t'(1);
                    fcu_pkg::COND_DBNZ: result = dec.a - fcu_pkg::fcu_word_t'(1);
                    default:            result = fcu_pkg::FILL_PATTERN;
                endcase
            end
            fcu_pkg::OP_JAL,
            fcu_pkg::OP_CALL:
                result = link_value;
            fcu_pkg::OP_RET:
                // Stack adjust
                result = dec.a + dec.i;
            fcu_pkg::OP_REX:
            begin
                if (dec.ol == fcu_pkg::OL_USER)
                begin
                    result = fcu_pkg::FILL_PATTERN;
                end
                else if (rex_taken)
                begin
                    result = dec.tvec;
                end
                else
                begin
                    result = link_value;
                end
            end
            fcu_pkg::OP_WAIT:
                result = wait_done ? fcu_pkg::fcu_word_t'(1) : '0;
            default:
                result = fcu_pkg::FILL_PATTERN;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/fcu_top.sv ====
// ==============================
// Flow control unit, response 2 cycles after issue
// No back-pressure, the consumer takes rsp in its valid cycle
// Response holds its last value between strobes
// ==============================
`timescale 1ns/1ps
`default_nettype none

module fcu_top (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              issue_valid,
    input  fcu_pkg::fcu_req_t req,
    output logic              rsp_valid,
    output fcu_pkg::fcu_rsp_t rsp
);

    logic               dec_valid;
    fcu_pkg::fcu_dec_t  dec;
    fcu_pkg::fcu_word_t result;
    fcu_pkg::fcu_flow_t flow;

    // ==============================
    // Stage 1
    // ==============================
    fcu_decode u_decode (
        .clk         (clk),
        .arst_n      (arst_n),
        .issue_valid (issue_valid),
        .req         (req),
        .dec_valid   (dec_valid),
        .dec         (dec)
    );

    // Both calculators share the record
    fcu_result_calc u_result_calc (
        .dec    (dec),
        .result (result)
    );

    fcu_branch_eval u_branch_eval (
        .dec  (dec),
        .flow (flow)
    );

    // ==============================
    // Stage 2 response register
    // ==============================
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            rsp_valid <= 1'b0;
            rsp       <= '0;
        end
        else
        begin
            rsp_valid <= dec_valid;
            // Load only valid records
            if (dec_valid)
            begin
                rsp.result <= result;
                rsp.flow   <= flow;
            end
        end
    end

endmodule

`default_nettype wire

// ==== tests/fcu_checker.sv ====
// ==============================
// Response timing and flow checks, bound into fcu_top
// Assumes a fixed 2-cycle latency and no back-pressure
// ==============================
`timescale 1ns/1ps
`default_nettype none

module fcu_checker (
    input logic              clk,
    input logic              arst_n,
    input logic              issue_valid,
    input logic              rsp_valid,
    input fcu_pkg::fcu_rsp_t rsp
);

    // Number of failed assertions so far
    int fail_count = 0;

    // Every issue is answered exactly two edges later
    a_latency: assert property (@(posedge clk) disable iff (!arst_n)
        issue_valid |-> ##2 rsp_valid)
    else
    begin
        fail_count++;
        $error("response missing 2 cycles after issue");
    end

    // No response without an issue two edges back
    a_no_orphan: assert property (@(posedge clk) disable iff (!arst_n)
        rsp_valid |-> $past(issue_valid, 2))
    else
    begin
        fail_count++;
        $error("response without a matching issue");
    end

    // Quiet output while reset is held
    a_reset_quiet: assert property (@(posedge clk)
        !arst_n |-> !rsp_valid)
    else
    begin
        fail_count++;
        $error("response valid during reset");
    end

    // Illegal cases never redirect
    a_flow_excl: assert property (@(posedge clk) disable iff (!arst_n)
        rsp_valid |-> !(rsp.flow.redirect && rsp.flow.illegal))
    else
    begin
        fail_count++;
        $error("redirect and illegal both set");
    end

endmodule

bind fcu_top fcu_checker u_checker (
    .clk         (clk),
    .arst_n      (arst_n),
    .issue_valid (issue_valid),
    .rsp_valid   (rsp_valid),
    .rsp         (rsp)
);

`default_nettype wire

// ==== tests/fcu_clock_gen.sv ====
// ==============================
// Testbench clock, 10 ns period
// Reset low for the first 10 rising edges
// ==============================
`timescale 1ns/1ps
`default_nettype none

module fcu_clock_gen (
    output logic clk,
    output logic arst_n
);

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Release lines up with a rising edge
    initial
    begin
        arst_n = 1'b0;
        repeat (10) @(posedge clk);
        arst_n <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== tests/fcu_tb.sv ====
// ==============================
// Table-driven testbench for fcu_top
// Operands from a 32-bit Fibonacci LFSR, seed 41
// Expected values follow the result and flow rules of the unit
// ==============================
`timescale 1ns/1ps
`default_nettype none

module fcu_tb;

    logic              clk;
    logic              arst_n;
    logic              issue_valid;
    fcu_pkg::fcu_req_t req;
    logic              rsp_valid;
    fcu_pkg::fcu_rsp_t rsp;

    // Stimulus table, one entry per row
    string             name_tab[$];
    fcu_pkg::fcu_req_t req_tab[$];
    fcu_pkg::fcu_rsp_t exp_tab[$];
    int                gap_tab[$];

    // In-flight rows and the cycle each one is due
    int          pend_row[$];
    int          pend_due[$];
    int          issue_row;
    int          cyc = 0;
    int          err_count = 0;
    int          done_count = 0;
    logic        hard_fail = 1'b0;
    logic [31:0] lfsr_state;

    fcu_clock_gen u_clock_gen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    fcu_top dut (
        .clk         (clk),
        .arst_n      (arst_n),
        .issue_valid (issue_valid),
        .req         (req),
        .rsp_valid   (rsp_valid),
        .rsp         (rsp)
    );

    // ==============================
    // Stimulus helpers
    // ==============================
    // Taps 32, 22, 2, 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic fcu_pkg::fcu_word_t rand_bits(input int n);
        fcu_pkg::fcu_word_t v;
        int                 b;
        v = '0;
        for (b = 0; b < n; b++)
            v = {v[62:0], lfsr_bit()};
        return v;
    endfunction

    // disp 31:20, cond 19:17, cause 12:6, opcode 5:0
    function automatic logic [31:0] make_instr(input logic [5:0] opc, input logic [6:0] cause,
                                               input logic [2:0] cond, input logic [11:0] disp);
        return {disp, cond, 4'b0000, cause, opc};
    endfunction

    function automatic fcu_pkg::fcu_req_t random_req(input logic [31:0] instr);
        fcu_pkg::fcu_req_t r;
        r.instr   = instr;
        r.a       = rand_bits(64);
        r.i       = rand_bits(64);
        r.next_pc = fcu_pkg::fcu_addr_t'(rand_bits(30) << 2);
        r.link    = fcu_pkg::fcu_addr_t'(rand_bits(30) << 2);
        r.tvec    = rand_bits(64);
        r.waitctr = rand_bits(2);
        r.ol      = fcu_pkg::fcu_level_t'(rand_bits(3));
        r.im      = fcu_pkg::fcu_level_t'(rand_bits(3));
        return r;
    endfunction

    // Expected response worked out from the unit's rules
    function automatic fcu_pkg::fcu_rsp_t expect_rsp(input fcu_pkg::fcu_req_t r);
        logic [5:0]          opc;
        logic [2:0]          cond;
        logic [11:0]         d12;
        fcu_pkg::fcu_addr_t  disp_b;
        fcu_pkg::fcu_addr_t  tgt;
        fcu_pkg::fcu_level_t inv_lvl;
        fcu_pkg::fcu_rsp_t   e;
        opc     = r.instr[5:0];
        cond    = r.instr[19:17];
        d12     = r.instr[31:20];
        disp_b  = {{18{d12[11]}}, d12, 2'b00};
        inv_lvl = ~r.ol;
        tgt     = '0;
        e       = '0;
        e.result = fcu_pkg::FILL_PATTERN;
        case (opc)
            fcu_pkg::OP_BRK:
            begin
                e.result        = {{57{1'b1}}, r.instr[12:6]};
                e.flow.redirect = 1'b1;
                tgt             = r.tvec[31:0];
            end
            fcu_pkg::OP_BBC:
            begin
                tgt = r.next_pc + disp_b;
                if (cond == fcu_pkg::COND_IBNE)
                begin
                    e.result        = r.a + 64'd1;
                    e.flow.redirect = ((r.a + 64'd1) != r.i);
                end
                else if (cond == fcu_pkg::COND_DBNZ)
                begin
                    e.result        = r.a - 64'd1;
                    e.flow.redirect = ((r.a - 64'd1) != 64'd0);
                end
                else
                    e.flow.illegal = 1'b1;
            end
            fcu_pkg::OP_JAL,
            fcu_pkg::OP_CALL:
            begin
                e.result        = {32'd0, r.next_pc};
                e.flow.redirect = 1'b1;
                tgt             = r.a[31:0] + disp_b;
            end
            fcu_pkg::OP_RET:
            begin
                e.result        = r.a + r.i;
                e.flow.redirect = 1'b1;
                tgt             = r.link;
            end
            fcu_pkg::OP_REX:
            begin
                if (r.ol == 3'b011)
                    e.flow.illegal = 1'b1;
                else
                begin
                    e.flow.redirect = (r.im < inv_lvl);
                    e.result        = e.flow.redirect ? r.tvec : {32'd0, r.next_pc};
                    tgt             = r.tvec[31:0];
                end
            end
            fcu_pkg::OP_WAIT:
                e.result = {63'd0, (r.waitctr == 64'd1)};
            default:
                e.flow.illegal = 1'b1;
        endcase
        e.flow.target = e.flow.redirect ? tgt : '0;
        return e;
    endfunction

    task automatic push_row(input string name, input fcu_pkg::fcu_req_t r, input int gap);
        name_tab.push_back(name);
        req_tab.push_back(r);
        exp_tab.push_back(expect_rsp(r));
        gap_tab.push_back(gap);
    endtask

    // ==============================
    // Stimulus table
    // ==============================
    task automatic build_table();
        fcu_pkg::fcu_req_t r;
        push_row("brk", random_req(make_instr(fcu_pkg::OP_BRK, 7'h5A, 3'b000, 12'h000)), 1);
        push_row("ibne taken",
                 random_req(make_instr(fcu_pkg::OP_BBC, 7'h00, fcu_pkg::COND_IBNE, 12'h010)), 0);
        r = random_req(make_instr(fcu_pkg::OP_BBC, 7'h00, fcu_pkg::COND_IBNE, 12'hFF0));
        r.i = r.a + 64'd1;
        push_row("ibne not taken", r, 0);
        push_row("dbnz taken",
                 random_req(make_instr(fcu_pkg::OP_BBC, 7'h00, fcu_pkg::COND_DBNZ, 12'h7FF)), 2);
        // Counter reaching zero falls through
        r = random_req(make_instr(fcu_pkg::OP_BBC, 7'h00, fcu_pkg::COND_DBNZ, 12'h004));
        r.a = 64'd1;
        push_row("dbnz to zero", r, 0);
        r = random_req(make_instr(fcu_pkg::OP_BBC, 7'h00, fcu_pkg::COND_DBNZ, 12'h800));
        r.a = 64'd0;
        push_row("dbnz wrap", r, 1);
        push_row("bbc cond 000", random_req(make_instr(fcu_pkg::OP_BBC, 7'h00, 3'b000, 12'h010)), 0);
        push_row("bbc cond 101", random_req(make_instr(fcu_pkg::OP_BBC, 7'h00, 3'b101, 12'h010)), 3);
        push_row("jal", random_req(make_instr(fcu_pkg::OP_JAL, 7'h00, 3'b000, 12'h123)), 0);
        push_row("call", random_req(make_instr(fcu_pkg::OP_CALL, 7'h00, 3'b000, 12'hF80)), 0);
        push_row("ret", random_req(make_instr(fcu_pkg::OP_RET, 7'h00, 3'b000, 12'h000)), 2);
        r = random_req(make_instr(fcu_pkg::OP_REX, 7'h00, 3'b000, 12'h000));
        r.ol = 3'b011;
        push_row("rex user", r, 1);
        // Mask 2 under inverted level 7
        r = random_req(make_instr(fcu_pkg::OP_REX, 7'h00, 3'b000, 12'h000));
        r.ol = 3'b000;
        r.im = 3'b010;
        push_row("rex taken", r, 0);
        r = random_req(make_instr(fcu_pkg::OP_REX, 7'h00, 3'b000, 12'h000));
        r.ol = 3'b101;
        r.im = 3'b011;
        push_row("rex not taken", r, 0);
        // Mask equal to inverted level stays put
        r = random_req(make_instr(fcu_pkg::OP_REX, 7'h00, 3'b000, 12'h000));
        r.ol = 3'b100;
        r.im = 3'b011;
        push_row("rex mask equal", r, 1);
        r = random_req(make_instr(fcu_pkg::OP_WAIT, 7'h00, 3'b000, 12'h000));
        r.waitctr = 64'd1;
        push_row("wait one", r, 0);
        r = random_req(make_instr(fcu_pkg::OP_WAIT, 7'h00, 3'b000, 12'h000));
        r.waitctr = 64'd0;
        push_row("wait zero", r, 0);
        r = random_req(make_instr(fcu_pkg::OP_WAIT, 7'h00, 3'b000, 12'h000));
        r.waitctr = 64'd2;
        push_row("wait two", r, 1);
        push_row("undef 05", random_req(make_instr(6'h05, 7'h11, 3'b110, 12'h010)), 0);
        push_row("undef 3f", random_req(make_instr(6'h3F, 7'h22, 3'b111, 12'h010)), 0);
        push_row("brk zero", random_req(make_instr(fcu_pkg::OP_BRK, 7'h00, 3'b000, 12'h000)), 0);
        // Random instruction words back to back
        repeat (4)
            push_row("random", random_req(32'(rand_bits(32))), 0);
    endtask

    // ==============================
    // Compare tasks
    // ==============================
    task automatic check_result(input string tag, input fcu_pkg::fcu_word_t got,
                                input fcu_pkg::fcu_word_t exp);
        if (got !== exp)
        begin
            $display("ERROR %0t: %s result %h, expected %h", $time, tag, got, exp);
            err_count++;
        end
    endtask

    task automatic check_flow(input string tag, input fcu_pkg::fcu_flow_t got,
                              input fcu_pkg::fcu_flow_t exp);
        if (got !== exp)
        begin
            $display("ERROR %0t: %s flow redirect=%b target=%h illegal=%b, expected %b %h %b",
                     $time, tag, got.redirect, got.target, got.illegal,
                     exp.redirect, exp.target, exp.illegal);
            err_count++;
        end
    endtask

    // ==============================
    // Response monitor
    // ==============================
    // Sampled at the falling edge, away from the DUT's register updates
    always @(negedge clk)
    begin
        int row;
        int due;
        int errs_before;
        cyc = cyc + 1;
        if (rsp_valid)
        begin
            if (pend_row.size() == 0)
            begin
                $display("Unexpected response at %0t with no instruction in flight", $time);
                hard_fail = 1'b1;
            end
            else
            begin
                row         = pend_row.pop_front();
                due         = pend_due.pop_front();
                errs_before = err_count;
                if (due != cyc)
                begin
                    $display("ERROR %0t: row %0d answered at cycle %0d, expected %0d",
                             $time, row, cyc, due);
                    err_count++;
                end
                check_result(name_tab[row], rsp.result, exp_tab[row].result);
                check_flow(name_tab[row], rsp.flow, exp_tab[row].flow);
                $display("row %0d %s: %s", row, name_tab[row],
                         (err_count == errs_before) ? "ok" : "FAIL");
                done_count++;
            end
        end
        if (issue_valid)
        begin
            pend_row.push_back(issue_row);
            pend_due.push_back(cyc + 2);
        end
    end

    // ==============================
    // Driver
    // ==============================
    initial
    begin
        int t;
        int k;
        issue_valid = 1'b0;
        req         = '0;
        issue_row   = 0;
        lfsr_state  = 32'd41;
        build_table();

        // Reset reads as unknown until the clock module drives it
        t = 0;
        while (arst_n !== 1'b1 && t < 100)
        begin
            @(posedge clk);
            t++;
        end
        if (arst_n !== 1'b1)
        begin
            $display("Reset was never released");
            hard_fail = 1'b1;
        end
        else
        begin
            // Response registers come out of reset cleared
            @(negedge clk);
            check_result("after reset", rsp.result, '0);
            check_flow("after reset", rsp.flow, '0);
            repeat (2) @(posedge clk);

            for (k = 0; k < req_tab.size(); k++)
            begin
                @(posedge clk);
                issue_valid <= 1'b1;
                req         <= req_tab[k];
                issue_row   <= k;
                repeat (gap_tab[k])
                begin
                    @(posedge clk);
                    issue_valid <= 1'b0;
                end
            end
            @(posedge clk);
            issue_valid <= 1'b0;

            // Drain the in-flight responses
            t = 0;
            while (done_count < req_tab.size() && t < 20)
            begin
                @(posedge clk);
                t++;
            end
            if (done_count < req_tab.size())
            begin
                $display("Timed out with %0d responses missing", req_tab.size() - done_count);
                hard_fail = 1'b1;
            end
            repeat (3) @(posedge clk);
        end

        $display("rows %0d, checked %0d, errors %0d, assertion failures %0d",
                 req_tab.size(), done_count, err_count, dut.u_checker.fail_count);
        if (err_count == 0 && !hard_fail && dut.u_checker.fail_count == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire
